/* src/fpga_mem_pkg.sv */
`default_nettype none

package fpga_mem_pkg;

  // Memory select, taken from CPU address bits 16:15
  localparam logic [1:0] bram_sel_controller = 2'd0;
  localparam logic [1:0] bram_sel_mod        = 2'd1;
  localparam logic [1:0] bram_sel_pwe_table  = 2'd2;
  localparam logic [1:0] bram_sel_stm        = 2'd3;

  // Controller sub-select in word address bits 11:8
  localparam logic [3:0] cnt_sel_main  = 4'h0;
  localparam logic [3:0] cnt_sel_clock = 4'h1;

  // Main registers that also drive memory selects
  localparam logic [7:0] addr_mod_mem_wr_segment = 8'h20;
  localparam logic [7:0] addr_mod_req_rd_segment = 8'h21;
  localparam logic [7:0] addr_stm_mem_wr_segment = 8'h50;
  localparam logic [7:0] addr_stm_mem_wr_page    = 8'h51;

  // Controller word address, read as a register address or as a clock table slot
  typedef union packed {
    struct packed {
      logic [1:0] pad;
      logic [3:0] sub_sel;
      logic [7:0] reg_addr;
    } main;
    struct packed {
      logic [1:0] pad;
      logic [3:0] sub_sel;
      logic       pad_entry;
      logic [4:0] entry;   // One of 32 table entries
      logic [1:0] part;    // 16-bit slice 0..2 of the 39-bit entry
    } clock;
  } ctl_addr_u;

endpackage

`default_nettype wire

/* src/memory_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Internal bus from the CPU bridge to the memories
interface memory_bus_if;

  logic        wr;     // Single-cycle write strobe
  logic [1:0]  sel;
  logic [13:0] addr;   // Word address
  logic [15:0] wdata;

  modport bridge (
    output wr,
    output sel,
    output addr,
    output wdata
  );

  modport mem (
    input wr,
    input sel,
    input addr,
    input wdata
  );

endinterface

`default_nettype wire

/* src/cpu_bus_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_bridge (
  input  wire         CPU_CKIO,
  input  wire         rst,
  input  wire         cpu_cn,
  input  wire         cpu_we0_n,
  input  wire  [16:0] cpu_addr,
  input  wire  [15:0] cpu_data_in,
  output logic [15:0] cpu_data_out,
  input  wire  [15:0] ctl_rdata,
  input  wire  [15:0] mod_rdata,
  input  wire  [15:0] stm_rdata,
  input  wire  [15:0] pwe_rdata,
  memory_bus_if.bridge bus
);

  logic        cn_q;
  logic        we_n_q;
  logic        we_n_d;     // Previous registered write enable
  logic [16:1] addr_q;     // Byte address bit 0 is never used
  logic [15:0] data_q;
  logic [1:0]  rd_sel;     // Select aligned with memory read data

  always_ff @(posedge CPU_CKIO) begin
    addr_q <= cpu_addr[16:1];
    data_q <= cpu_data_in;
  end

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      cn_q         <= 1'b1;
      we_n_q       <= 1'b1;
      we_n_d       <= 1'b1;
      bus.wr       <= 1'b0;
      rd_sel       <= 2'd0;
      cpu_data_out <= 16'h0000;
    end else begin
      cn_q   <= cpu_cn;
      we_n_q <= cpu_we0_n;
      we_n_d <= we_n_q;
      bus.wr <= ~cn_q & ~we_n_q & we_n_d;  // Falling edge of WE while enabled
      rd_sel <= bus.sel;
      case (rd_sel)
        fpga_mem_pkg::bram_sel_controller: cpu_data_out <= ctl_rdata;
        fpga_mem_pkg::bram_sel_mod:        cpu_data_out <= mod_rdata;
        fpga_mem_pkg::bram_sel_pwe_table:  cpu_data_out <= pwe_rdata;
        fpga_mem_pkg::bram_sel_stm:        cpu_data_out <= stm_rdata;
      endcase
    end
  end

  assign bus.sel   = addr_q[16:15];
  assign bus.addr  = addr_q[14:1];
  assign bus.wdata = data_q;

endmodule

`default_nettype wire

/* src/controller_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module controller_regs (
  input  wire         CPU_CKIO,
  input  wire         rst,
  memory_bus_if.mem   bus,
  output logic [15:0] rdata,
  output logic        mod_wr_segment,
  output logic        mod_rd_segment,
  output logic        stm_wr_segment,
  output logic [3:0]  stm_wr_page
);

  fpga_mem_pkg::ctl_addr_u ctl_addr;

  logic        ctl_hit;
  logic        main_wr;
  logic        clock_wr;
  logic [15:0] main_regs [256] = '{default: '0};
  logic [38:0] clk_table [32]  = '{default: '0};

  assign ctl_addr = bus.addr;
  assign ctl_hit  = bus.wr && (bus.sel == fpga_mem_pkg::bram_sel_controller);
  assign main_wr  = ctl_hit && (ctl_addr.main.sub_sel == fpga_mem_pkg::cnt_sel_main);
  assign clock_wr = ctl_hit && (ctl_addr.clock.sub_sel == fpga_mem_pkg::cnt_sel_clock);

  always_ff @(posedge CPU_CKIO) begin
    if (main_wr) main_regs[ctl_addr.main.reg_addr] <= bus.wdata;
    if (clock_wr) begin
      case (ctl_addr.clock.part)
        2'd0: clk_table[ctl_addr.clock.entry][15:0]  <= bus.wdata;
        2'd1: clk_table[ctl_addr.clock.entry][31:16] <= bus.wdata;
        2'd2: clk_table[ctl_addr.clock.entry][38:32] <= bus.wdata[6:0];  // Top 7 bits only
      endcase
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    case (ctl_addr.main.sub_sel)
      fpga_mem_pkg::cnt_sel_main: rdata <= main_regs[ctl_addr.main.reg_addr];
      fpga_mem_pkg::cnt_sel_clock: begin
        case (ctl_addr.clock.part)
          2'd0:    rdata <= clk_table[ctl_addr.clock.entry][15:0];
          2'd1:    rdata <= clk_table[ctl_addr.clock.entry][31:16];
          2'd2:    rdata <= {9'd0, clk_table[ctl_addr.clock.entry][38:32]};
          default: rdata <= 16'h0000;
        endcase
      end
      default: rdata <= 16'h0000;
    endcase
  end

  // Shadow copies that steer the memories
  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      mod_wr_segment <= 1'b0;
      mod_rd_segment <= 1'b0;
      stm_wr_segment <= 1'b0;
      stm_wr_page    <= 4'd0;
    end else if (main_wr) begin
      case (ctl_addr.main.reg_addr)
        fpga_mem_pkg::addr_mod_mem_wr_segment: mod_wr_segment <= bus.wdata[0];
        fpga_mem_pkg::addr_mod_req_rd_segment: mod_rd_segment <= bus.wdata[0];
        fpga_mem_pkg::addr_stm_mem_wr_segment: stm_wr_segment <= bus.wdata[0];
        fpga_mem_pkg::addr_stm_mem_wr_page:    stm_wr_page    <= bus.wdata[3:0];
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/mod_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module mod_memory #(
  parameter int mod_depth = 64
) (
  input  wire         CPU_CKIO,
  memory_bus_if.mem   bus,
  input  wire         wr_segment,
  input  wire         rd_segment,
  output logic [15:0] rdata,
  input  wire  [7:0]  mod_idx,
  output logic [7:0]  mod_value
);

  localparam int idx_bits = $clog2(mod_depth);

  logic [15:0]         mem [2*mod_depth] = '{default: '0};
  logic [idx_bits-1:0] bus_word;
  logic [idx_bits-1:0] fab_word;
  logic [idx_bits:0]   bus_ptr;
  logic [idx_bits:0]   fab_ptr;
  logic [15:0]         fab_q;
  logic                fab_hi;   // Odd index, upper byte

  assign bus_word = idx_bits'(bus.addr % mod_depth);
  assign fab_word = idx_bits'(mod_idx[7:1] % mod_depth);

  // Segment 1 sits after the full segment 0
  assign bus_ptr = wr_segment ? (idx_bits+1)'(mod_depth) + bus_word : {1'b0, bus_word};
  assign fab_ptr = rd_segment ? (idx_bits+1)'(mod_depth) + fab_word : {1'b0, fab_word};

  always_ff @(posedge CPU_CKIO) begin
    if (bus.wr && (bus.sel == fpga_mem_pkg::bram_sel_mod)) mem[bus_ptr] <= bus.wdata;
    rdata <= mem[bus_ptr];
  end

  always_ff @(posedge CPU_CKIO) begin
    fab_q  <= mem[fab_ptr];
    fab_hi <= mod_idx[0];
  end

  assign mod_value = fab_hi ? fab_q[15:8] : fab_q[7:0];

endmodule

`default_nettype wire

/* src/stm_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_memory #(
  parameter int stm_addr_bits = 8,
  parameter int stm_page_bits = 1
) (
  input  wire         CPU_CKIO,
  memory_bus_if.mem   bus,
  input  wire         wr_segment,
  input  wire  [3:0]  wr_page,
  output logic [15:0] rdata
);

  localparam int ptr_bits = 1 + stm_page_bits + stm_addr_bits;
  localparam int depth    = 2 ** ptr_bits;

  logic [15:0]         mem [depth] = '{default: '0};
  logic [ptr_bits-1:0] ptr;
  logic                stm_wr;

  // Segment on top, then page, then the word within the page
  assign ptr = {wr_segment, wr_page[stm_page_bits-1:0], bus.addr[stm_addr_bits-1:0]};

  assign stm_wr = bus.wr && (bus.sel == fpga_mem_pkg::bram_sel_stm);

  always_ff @(posedge CPU_CKIO) begin
    if (stm_wr) mem[ptr] <= bus.wdata;
    rdata <= mem[ptr];
  end

endmodule

`default_nettype wire

/* src/pwe_table.sv */
`timescale 1ns/1ps
`default_nettype none

module pwe_table (
  input  wire         CPU_CKIO,
  memory_bus_if.mem   bus,
  output logic [15:0] rdata,
  input  wire  [7:0]  pwe_idx,
  output logic [7:0]  pwe_value
);

  logic [15:0] mem [128] = '{default: '0};  // Two table entries per word
  logic [15:0] fab_q;
  logic        fab_hi;

  always_ff @(posedge CPU_CKIO) begin
    if (bus.wr && (bus.sel == fpga_mem_pkg::bram_sel_pwe_table)) begin
      mem[bus.addr[6:0]] <= bus.wdata;
    end
    rdata <= mem[bus.addr[6:0]];
  end

  always_ff @(posedge CPU_CKIO) begin
    fab_q  <= mem[pwe_idx[7:1]];
    fab_hi <= pwe_idx[0];
  end

  assign pwe_value = fab_hi ? fab_q[15:8] : fab_q[7:0];

endmodule

`default_nettype wire

/* src/fpga_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fpga_mem_top #(
  parameter int mod_depth     = 64,
  parameter int stm_addr_bits = 8,
  parameter int stm_page_bits = 1
) (
  input  wire         CPU_CKIO,
  input  wire         rst,
  input  wire         cpu_cn,
  input  wire         cpu_we0_n,
  input  wire  [16:0] cpu_addr,
  input  wire  [15:0] cpu_data_in,
  output logic [15:0] cpu_data_out,
  input  wire  [7:0]  mod_idx,
  output logic [7:0]  mod_value,
  input  wire  [7:0]  pwe_idx,
  output logic [7:0]  pwe_value
);

  logic [15:0] ctl_rdata;
  logic [15:0] mod_rdata;
  logic [15:0] stm_rdata;
  logic [15:0] pwe_rdata;
  logic        mod_wr_segment;
  logic        mod_rd_segment;
  logic        stm_wr_segment;
  logic [3:0]  stm_wr_page;

  memory_bus_if memory_bus ();

  cpu_bus_bridge cpu_bus_bridge_inst (
    .CPU_CKIO     (CPU_CKIO),
    .rst          (rst),
    .cpu_cn       (cpu_cn),
    .cpu_we0_n    (cpu_we0_n),
    .cpu_addr     (cpu_addr),
    .cpu_data_in  (cpu_data_in),
    .cpu_data_out (cpu_data_out),
    .ctl_rdata    (ctl_rdata),
    .mod_rdata    (mod_rdata),
    .stm_rdata    (stm_rdata),
    .pwe_rdata    (pwe_rdata),
    .bus          (memory_bus.bridge)
  );

  controller_regs controller_regs_inst (
    .CPU_CKIO       (CPU_CKIO),
    .rst            (rst),
    .bus            (memory_bus.mem),
    .rdata          (ctl_rdata),
    .mod_wr_segment (mod_wr_segment),
    .mod_rd_segment (mod_rd_segment),
    .stm_wr_segment (stm_wr_segment),
    .stm_wr_page    (stm_wr_page)
  );

  mod_memory #(
    .mod_depth (mod_depth)
  ) mod_memory_inst (
    .CPU_CKIO   (CPU_CKIO),
    .bus        (memory_bus.mem),
    .wr_segment (mod_wr_segment),
    .rd_segment (mod_rd_segment),
    .rdata      (mod_rdata),
    .mod_idx    (mod_idx),
    .mod_value  (mod_value)
  );

  stm_memory #(
    .stm_addr_bits (stm_addr_bits),
    .stm_page_bits (stm_page_bits)
  ) stm_memory_inst (
    .CPU_CKIO   (CPU_CKIO),
    .bus        (memory_bus.mem),
    .wr_segment (stm_wr_segment),
    .wr_page    (stm_wr_page),
    .rdata      (stm_rdata)
  );

  pwe_table pwe_table_inst (
    .CPU_CKIO  (CPU_CKIO),
    .bus       (memory_bus.mem),
    .rdata     (pwe_rdata),
    .pwe_idx   (pwe_idx),
    .pwe_value (pwe_value)
  );

endmodule

`default_nettype wire

/* verif/fpga_mem_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module fpga_mem_properties (
  input wire        CPU_CKIO,
  input wire        rst,
  input wire        wr,
  input wire        cn_q,
  input wire        we_n_q,
  input wire [15:0] cpu_data_out
);

  int unsigned failures = 0;  // Failed assertion count

  wr_single_cycle: assert property (@(posedge CPU_CKIO) disable iff (rst) wr |=> !wr)
    else begin
      $error("write pulse lasted more than one cycle");
      failures++;
    end

  // Pulse needs chip enable and write enable both active one cycle earlier
  wr_after_enable: assert property (@(posedge CPU_CKIO) disable iff (rst)
      wr |-> $past(!cn_q && !we_n_q))
    else begin
      $error("write pulse without an active chip enable and write enable");
      failures++;
    end

  data_out_known: assert property (@(posedge CPU_CKIO) disable iff (rst)
      !$isunknown(cpu_data_out))
    else begin
      $error("cpu_data_out has unknown bits after reset");
      failures++;
    end

endmodule

bind cpu_bus_bridge fpga_mem_properties fpga_mem_properties_inst (
  .CPU_CKIO     (CPU_CKIO),
  .rst          (rst),
  .wr           (bus.wr),
  .cn_q         (cn_q),
  .we_n_q       (we_n_q),
  .cpu_data_out (cpu_data_out)
);

`default_nettype wire

/* verif/tb_fpga_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_mem;

  localparam int mod_depth     = 64;
  localparam int stm_addr_bits = 8;
  localparam int stm_page_bits = 1;

  // Bus and fabric operations per test at up to 8 cycles each
  localparam int ctl_ops    = 2 * (16 + 96);
  localparam int pwe_ops    = 2 * 128 + 256;
  localparam int mod_ops    = 6 + 8 * mod_depth;
  localparam int stm_ops    = 16 + 32 + 36;
  localparam int num_ops    = 4 + ctl_ops + pwe_ops + mod_ops + stm_ops;
  localparam int max_cycles = num_ops * 8 + 8 + 200;

  logic        CPU_CKIO;
  logic        rst;
  logic        cpu_cn;
  logic        cpu_we0_n;
  logic [16:0] cpu_addr;
  logic [15:0] cpu_data_in;
  logic [15:0] cpu_data_out;
  logic [7:0]  mod_idx;
  logic [7:0]  mod_value;
  logic [7:0]  pwe_idx;
  logic [7:0]  pwe_value;

  int unsigned errors = 0;
  int unsigned cycles = 0;
  logic [15:0] ctl_ref [int];  // Keyed by controller word address
  logic [15:0] mod_ref [int];
  logic [15:0] stm_ref [int];
  logic [15:0] pwe_ref [int];

  fpga_mem_top #(
    .mod_depth     (mod_depth),
    .stm_addr_bits (stm_addr_bits),
    .stm_page_bits (stm_page_bits)
  ) fpga_mem_top_inst (
    .CPU_CKIO     (CPU_CKIO),
    .rst          (rst),
    .cpu_cn       (cpu_cn),
    .cpu_we0_n    (cpu_we0_n),
    .cpu_addr     (cpu_addr),
    .cpu_data_in  (cpu_data_in),
    .cpu_data_out (cpu_data_out),
    .mod_idx      (mod_idx),
    .mod_value    (mod_value),
    .pwe_idx      (pwe_idx),
    .pwe_value    (pwe_value)
  );

  initial begin
    CPU_CKIO = 1'b0;
    forever #4 CPU_CKIO = ~CPU_CKIO;
  end

  initial begin
    while (cycles < max_cycles) begin
      @(posedge CPU_CKIO);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", max_cycles);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [16:0] cpu_byte_addr(input logic [1:0] sel, input logic [13:0] word);
    return {sel, word, 1'b0};
  endfunction

  function automatic int stm_key(input int s, input int p, input logic [13:0] word);
    return (s << (stm_page_bits + stm_addr_bits)) | (p << stm_addr_bits) |
           int'(word[stm_addr_bits-1:0]);
  endfunction

  task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp)
      else begin
        errors++;
        $display("error: %s is %h, expected %h", name, got, exp);
      end
  endtask

  // Enable and address first, then WE low for two cycles
  task automatic bus_write(input logic [1:0] sel, input logic [13:0] word,
                           input logic [15:0] data);
    @(negedge CPU_CKIO);
    cpu_cn      = 1'b0;
    cpu_addr    = cpu_byte_addr(sel, word);
    cpu_data_in = data;
    @(negedge CPU_CKIO);
    cpu_we0_n = 1'b0;
    repeat (2) @(negedge CPU_CKIO);
    cpu_we0_n = 1'b1;
    @(negedge CPU_CKIO);
    cpu_cn = 1'b1;
  endtask

  task automatic bus_read(input logic [1:0] sel, input logic [13:0] word,
                          output logic [15:0] data);
    @(negedge CPU_CKIO);
    cpu_cn   = 1'b0;
    cpu_addr = cpu_byte_addr(sel, word);
    repeat (4) @(negedge CPU_CKIO);
    data   = cpu_data_out;
    cpu_cn = 1'b1;
  endtask

  task automatic check_read(input logic [1:0] sel, input logic [13:0] word,
                            input logic [15:0] exp);
    logic [15:0] got;
    bus_read(sel, word, got);
    check_value($sformatf("cpu_data_out at %h", cpu_byte_addr(sel, word)), got, exp);
  endtask

  task automatic set_main(input logic [7:0] reg_addr, input logic [15:0] data);
    bus_write(fpga_mem_pkg::bram_sel_controller, {2'b00, fpga_mem_pkg::cnt_sel_main, reg_addr},
              data);
  endtask

  task automatic check_mod_byte(input logic [7:0] idx, input logic [7:0] exp);
    @(negedge CPU_CKIO);
    mod_idx = idx;
    @(negedge CPU_CKIO);
    check_value($sformatf("mod_value[%h]", idx), {8'h00, mod_value}, {8'h00, exp});
  endtask

  task automatic check_pwe_byte(input logic [7:0] idx, input logic [7:0] exp);
    @(negedge CPU_CKIO);
    pwe_idx = idx;
    @(negedge CPU_CKIO);
    check_value($sformatf("pwe_value[%h]", idx), {8'h00, pwe_value}, {8'h00, exp});
  endtask

  task automatic test_reset_values();
    for (int s = 0; s < 4; s++) check_read(2'(s), 14'h0000, 16'h0000);
  endtask

  task automatic test_controller();
    logic [13:0] word;
    logic [15:0] data;
    for (int i = 0; i < 16; i++) begin
      word = {2'b00, fpga_mem_pkg::cnt_sel_main, 1'b1, 7'($urandom)};  // Clear of named regs
      data = 16'($urandom);
      bus_write(fpga_mem_pkg::bram_sel_controller, word, data);
      ctl_ref[int'(word)] = data;
    end
    for (int e = 0; e < 32; e++) begin
      for (int p = 0; p < 3; p++) begin
        word = {2'b00, fpga_mem_pkg::cnt_sel_clock, 1'b0, 5'(e), 2'(p)};
        data = 16'($urandom);
        bus_write(fpga_mem_pkg::bram_sel_controller, word, data);
        ctl_ref[int'(word)] = (p == 2) ? {9'd0, data[6:0]} : data;
      end
    end
    foreach (ctl_ref[k]) check_read(fpga_mem_pkg::bram_sel_controller, 14'(k), ctl_ref[k]);
  endtask

  task automatic test_pwe();
    logic [15:0] data;
    for (int w = 0; w < 128; w++) begin
      data = 16'($urandom);
      // Upper address bits set at random must not matter
      bus_write(fpga_mem_pkg::bram_sel_pwe_table, 14'(w) | (14'($urandom) & 14'h3f80), data);
      pwe_ref[w] = data;
    end
    for (int i = 0; i < 256; i++) begin
      data = pwe_ref[i / 2];
      check_pwe_byte(8'(i), (i % 2) ? data[15:8] : data[7:0]);
    end
    for (int w = 0; w < 128; w++) check_read(fpga_mem_pkg::bram_sel_pwe_table, 14'(w), pwe_ref[w]);
  endtask

  task automatic test_mod();
    logic [15:0] data;
    for (int s = 0; s < 2; s++) begin
      set_main(fpga_mem_pkg::addr_mod_mem_wr_segment, 16'(s));
      for (int w = 0; w < mod_depth; w++) begin
        data = 16'($urandom);
        if (s == 1 && data == mod_ref[w]) data = ~data;  // Segments must differ
        bus_write(fpga_mem_pkg::bram_sel_mod, 14'(w), data);
        mod_ref[s * mod_depth + w] = data;
      end
    end
    for (int s = 0; s < 2; s++) begin
      set_main(fpga_mem_pkg::addr_mod_req_rd_segment, 16'(s));
      for (int i = 0; i < 2 * mod_depth; i++) begin
        data = mod_ref[s * mod_depth + i / 2];
        check_mod_byte(8'(i), (i % 2) ? data[15:8] : data[7:0]);
      end
    end
    for (int s = 0; s < 2; s++) begin
      set_main(fpga_mem_pkg::addr_mod_mem_wr_segment, 16'(s));
      for (int w = 0; w < mod_depth; w++) begin
        check_read(fpga_mem_pkg::bram_sel_mod, 14'(w), mod_ref[s * mod_depth + w]);
      end
    end
  endtask

  task automatic test_stm();
    logic [15:0] data;
    for (int s = 0; s < 2; s++) begin
      for (int p = 0; p < 2; p++) begin
        set_main(fpga_mem_pkg::addr_stm_mem_wr_segment, 16'(s));
        set_main(fpga_mem_pkg::addr_stm_mem_wr_page, 16'(p));
        for (int k = 0; k < 8; k++) begin
          data = 16'($urandom);
          bus_write(fpga_mem_pkg::bram_sel_stm, 14'(k * 29), data);
          stm_ref[stm_key(s, p, 14'(k * 29))] = data;
        end
      end
    end
    // Same offsets in every page let a stray write show up here
    for (int s = 0; s < 2; s++) begin
      for (int p = 0; p < 2; p++) begin
        set_main(fpga_mem_pkg::addr_stm_mem_wr_segment, 16'(s));
        set_main(fpga_mem_pkg::addr_stm_mem_wr_page, 16'(p));
        for (int k = 0; k < 8; k++) begin
          check_read(fpga_mem_pkg::bram_sel_stm, 14'(k * 29), stm_ref[stm_key(s, p, 14'(k * 29))]);
        end
        // Address bits above the page offset alias to the same word
        check_read(fpga_mem_pkg::bram_sel_stm, (14'h3fff << stm_addr_bits) | 14'd29,
                   stm_ref[stm_key(s, p, 14'd29)]);
      end
    end
  endtask

  initial begin
    void'($urandom(32'hadb7599c));
    rst         = 1'b1;
    cpu_cn      = 1'b1;
    cpu_we0_n   = 1'b1;
    cpu_addr    = '0;
    cpu_data_in = '0;
    mod_idx     = '0;
    pwe_idx     = '0;
    repeat (8) @(negedge CPU_CKIO);
    rst = 1'b0;
    test_reset_values();
    test_controller();
    test_pwe();
    test_mod();
    test_stm();
    $display("errors: %0d check, %0d assertion", errors,
             fpga_mem_top_inst.cpu_bus_bridge_inst.fpga_mem_properties_inst.failures);
    if (errors == 0 &&
        fpga_mem_top_inst.cpu_bus_bridge_inst.fpga_mem_properties_inst.failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* fpga_mem.f */
src/fpga_mem_pkg.sv
src/memory_bus_if.sv
src/cpu_bus_bridge.sv
src/controller_regs.sv
src/mod_memory.sv
src/stm_memory.sv
src/pwe_table.sv
src/fpga_mem_top.sv
verif/fpga_mem_properties.sv
verif/tb_fpga_mem.sv
